//--- files.f
+incdir+tests
design/axi_mem_pkg.sv
design/burst_addr_gen.sv
design/mem_array.sv
design/axi_read_engine.sv
design/axi_write_engine.sv
design/axi_mem_slave.sv
tests/axi_mem_tb.sv

//--- tests/axi_mem_tb_tasks.svh
// ======================================================================
// bus driving and compare tasks, included inside the testbench module
// ======================================================================
`ifndef AXI_MEM_TB_TASKS_SVH
`define AXI_MEM_TB_TASKS_SVH
`default_nettype none

task automatic check_data(input string name, input axi_mem_pkg::data_t got,
                          input axi_mem_pkg::data_t exp);
   if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
   end
endtask

task automatic check_resp(input string name, input axi_mem_pkg::resp_t got,
                          input axi_mem_pkg::resp_t exp);
   if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
   end
endtask

task automatic check_last(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
   end
endtask

// one clock, then past the drive delay
task automatic step();
   @(posedge clk);
   #1;
endtask

// AW then W beats, last asserted on beat last_at; b_ready held low b_hold cycles
task automatic write_burst(input axi_mem_pkg::ax_req_t req, input bit mixed,
                           input int last_at, input axi_mem_pkg::resp_t exp,
                           input int b_hold);
   axi_mem_pkg::addr_t a;
   bit fired;
   bit seen;
   int held;
   int i;
   aw = req;
   aw_valid = 1'b1;
   do begin
      @(negedge clk);
      fired = aw_ready;
      step();
   end while (!fired);
   aw_valid = 1'b0;
   for (i = 0; i <= req.len; i++) begin
      w.data = {$random(seed), $random(seed)};
      w.strb = mixed ? axi_mem_pkg::strb_t'($random(seed)) : 8'hff;
      w.last = (i == last_at);
      w_valid = 1'b1;
      do begin
         @(negedge clk);
         fired = w_ready;
         a = expected_addr(req, i);
         if (fired && in_window(a)) model_write(a, w.data, w.strb);
         step();
      end while (!fired);
   end
   w_valid = 1'b0;
   seen = 1'b0;
   held = 0;
   fired = 1'b0;
   while (!fired) begin
      b_ready = (held >= b_hold);
      @(negedge clk);
      if (b_valid) begin
         seen = 1'b1;
         if (b_ready) begin
            check_resp("b_resp", b_resp, exp);
            fired = 1'b1;
         end else begin
            held++;
         end
      end else if (seen) begin
         $display("b_valid dropped before b_ready was raised");
         errors++;
         fired = 1'b1;
      end
      step();
   end
   b_ready = 1'b0;
endtask

// AR then R beats, r_ready randomly stalled when stall is set
task automatic read_burst(input axi_mem_pkg::ax_req_t req, input bit stall,
                          input bit check_lat);
   axi_mem_pkg::addr_t a;
   axi_mem_pkg::data_t held_data;
   bit held;
   bit fired;
   bit started;
   int beat;
   int lat;
   ar = req;
   ar_valid = 1'b1;
   do begin
      @(negedge clk);
      fired = ar_ready;
      step();
   end while (!fired);
   ar_valid = 1'b0;
   beat = 0;
   lat = 0;
   held = 1'b0;
   started = 1'b0;
   while (beat <= req.len) begin
      r_ready = stall ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge clk);
      if (!started) lat++;  // cycles since the AR transfer
      if (r_valid) begin
         if (!started && check_lat && lat != 2) begin
            $display("r_valid rose %0d cycles after the AR transfer, not 2", lat);
            errors++;
         end
         started = 1'b1;
         if (held) check_data("r.data while stalled", r.data, held_data);
         if (r_ready) begin
            a = expected_addr(req, beat);
            check_data("r.data", r.data, in_window(a) ? model[word_of(a)] : '0);
            check_resp("r.resp", r.resp,
                       in_window(a) ? axi_mem_pkg::resp_okay : axi_mem_pkg::resp_decerr);
            check_last("r.last", r.last, beat == req.len);
            beat++;
            held = 1'b0;
         end else begin
            held = 1'b1;
            held_data = r.data;
         end
      end else if (held) begin
         $display("r_valid dropped while r_ready was low");
         errors++;
         held = 1'b0;
      end
      step();
   end
   r_ready = 1'b0;
endtask

`default_nettype wire
`endif

//--- tests/axi_mem_tb.sv
// ======================================================================
// directed testbench for the AXI burst memory slave, with a model memory
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module axi_mem_tb;

   localparam axi_mem_pkg::addr_t mem_base = 32'h8000_0000;  // DUT defaults
   localparam integer mem_words_log2 = 12;
   localparam integer test_cycles = 2000;  // rough sum over all tests
   localparam integer timeout_cycles = 2 * test_cycles;

   logic                 clk;
   logic                 rst;
   axi_mem_pkg::ax_req_t ar;
   logic                 ar_valid;
   logic                 ar_ready;
   axi_mem_pkg::r_beat_t r;
   logic                 r_valid;
   logic                 r_ready;
   axi_mem_pkg::ax_req_t aw;
   logic                 aw_valid;
   logic                 aw_ready;
   axi_mem_pkg::w_beat_t w;
   logic                 w_valid;
   logic                 w_ready;
   axi_mem_pkg::resp_t   b_resp;
   logic                 b_valid;
   logic                 b_ready;

   axi_mem_pkg::data_t model [axi_mem_pkg::addr_t];  // keyed by word address
   integer seed;
   int errors;
   int tests;
   int cycles = 0;

   axi_mem_slave dut0 (.*);

   function automatic axi_mem_pkg::addr_t word_of(axi_mem_pkg::addr_t a);
      return a & ~32'd7;
   endfunction

   function automatic bit in_window(axi_mem_pkg::addr_t a);
      return (a >= mem_base) && ((a - mem_base) < (32'd8 << mem_words_log2));
   endfunction

   // byte address of beat n, from the burst rules
   function automatic axi_mem_pkg::addr_t expected_addr(axi_mem_pkg::ax_req_t q, int n);
      axi_mem_pkg::addr_t step_bytes;
      axi_mem_pkg::addr_t block;
      axi_mem_pkg::addr_t lo;
      step_bytes = 32'd1 << q.size;
      block = step_bytes * (axi_mem_pkg::addr_t'(q.len) + 32'd1);
      lo = q.addr - (q.addr % block);
      case (q.burst)
         axi_mem_pkg::burst_fixed: return q.addr;
         axi_mem_pkg::burst_wrap:  return lo + (q.addr - lo + n * step_bytes) % block;
         default:                  return q.addr + n * step_bytes;
      endcase
   endfunction

   function automatic void model_write(axi_mem_pkg::addr_t a, axi_mem_pkg::data_t d,
                                       axi_mem_pkg::strb_t s);
      axi_mem_pkg::data_t word;
      word = model.exists(word_of(a)) ? model[word_of(a)] : '0;
      for (int k = 0; k < 8; k++) begin
         if (s[k]) word[8*k +: 8] = d[8*k +: 8];
      end
      model[word_of(a)] = word;
   endfunction

   function automatic axi_mem_pkg::ax_req_t make_req(axi_mem_pkg::addr_t a, int len,
                                                     axi_mem_pkg::burst_t kind);
      axi_mem_pkg::ax_req_t q;
      q.addr = a;
      q.len = axi_mem_pkg::len_t'(len);
      q.size = 3'd3;  // full 64-bit beats
      q.burst = kind;
      return q;
   endfunction

   `include "axi_mem_tb_tasks.svh"

   task automatic end_test(input string name, input int e0);
      tests++;
      $display("test %0d %s finished with %0d errors", tests, name, errors - e0);
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == timeout_cycles) begin
         $display("timeout: tests still running after %0d cycles", timeout_cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   initial begin
      int e0;
      seed = 32'h21e5_29ae;
      errors = 0;
      tests = 0;
      rst = 1'b1;
      ar = '0;
      ar_valid = 1'b0;
      r_ready = 1'b0;
      aw = '0;
      aw_valid = 1'b0;
      w = '0;
      w_valid = 1'b0;
      b_ready = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      e0 = errors;
      @(negedge clk);
      check_last("ar_ready", ar_ready, 1'b1);
      check_last("aw_ready", aw_ready, 1'b1);
      check_last("r_valid", r_valid, 1'b0);
      check_last("w_ready", w_ready, 1'b0);
      check_last("b_valid", b_valid, 1'b0);
      step();
      write_burst(make_req(mem_base, 0, axi_mem_pkg::burst_incr), 0, 0,
                  axi_mem_pkg::resp_okay, 0);
      read_burst(make_req(mem_base, 0, axi_mem_pkg::burst_incr), 0, 1);
      end_test("reset state and single beat", e0);

      e0 = errors;  // full words first, then mixed strobes over them
      write_burst(make_req(mem_base + 32'h100, 15, axi_mem_pkg::burst_incr), 0, 15,
                  axi_mem_pkg::resp_okay, 0);
      write_burst(make_req(mem_base + 32'h100, 15, axi_mem_pkg::burst_incr), 1, 15,
                  axi_mem_pkg::resp_okay, 0);
      read_burst(make_req(mem_base + 32'h100, 15, axi_mem_pkg::burst_incr), 0, 0);
      end_test("incr burst with strobes", e0);

      e0 = errors;
      write_burst(make_req(mem_base + 32'h400, 31, axi_mem_pkg::burst_incr), 0, 31,
                  axi_mem_pkg::resp_okay, 0);
      read_burst(make_req(mem_base + 32'h400, 31, axi_mem_pkg::burst_incr), 1, 0);
      end_test("read back-pressure", e0);

      e0 = errors;
      write_burst(make_req(mem_base + 32'h800, 3, axi_mem_pkg::burst_fixed), 0, 3,
                  axi_mem_pkg::resp_okay, 0);
      read_burst(make_req(mem_base + 32'h800, 0, axi_mem_pkg::burst_incr), 0, 0);
      write_burst(make_req(mem_base + 32'h920, 7, axi_mem_pkg::burst_wrap), 0, 7,
                  axi_mem_pkg::resp_okay, 0);
      read_burst(make_req(mem_base + 32'h900, 7, axi_mem_pkg::burst_incr), 0, 0);
      read_burst(make_req(mem_base + 32'h928, 7, axi_mem_pkg::burst_wrap), 0, 0);
      end_test("fixed and wrap addressing", e0);

      e0 = errors;
      // would alias word 0 if the window check were missing
      write_burst(make_req(32'h1000_0000, 3, axi_mem_pkg::burst_incr), 0, 3,
                  axi_mem_pkg::resp_decerr, 0);
      read_burst(make_req(mem_base, 0, axi_mem_pkg::burst_incr), 0, 0);
      read_burst(make_req(32'h1000_0000, 1, axi_mem_pkg::burst_incr), 0, 0);
      write_burst(make_req(mem_base + 32'ha00, 3, axi_mem_pkg::burst_incr), 0, 2,
                  axi_mem_pkg::resp_slverr, 3);
      read_burst(make_req(mem_base + 32'ha00, 3, axi_mem_pkg::burst_incr), 0, 0);
      end_test("error responses", e0);

      e0 = errors;
      fork
         write_burst(make_req(mem_base + 32'hc00, 7, axi_mem_pkg::burst_incr), 0, 7,
                     axi_mem_pkg::resp_okay, 0);
         read_burst(make_req(mem_base + 32'h400, 15, axi_mem_pkg::burst_incr), 0, 0);
      join
      read_burst(make_req(mem_base + 32'hc00, 7, axi_mem_pkg::burst_incr), 0, 0);
      end_test("concurrent traffic", e0);

      $display("tests run %0d, errors %0d", tests, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- design/axi_mem_slave.sv
// ======================================================================
// AXI burst memory slave top, read and write engines over one memory
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module axi_mem_slave #(
   parameter axi_mem_pkg::addr_t mem_base       = 32'h8000_0000,
   parameter integer             mem_words_log2 = 12
) (
   input  logic                 clk,
   input  logic                 rst,
   input  axi_mem_pkg::ax_req_t ar,
   input  logic                 ar_valid,
   output logic                 ar_ready,
   output axi_mem_pkg::r_beat_t r,
   output logic                 r_valid,
   input  logic                 r_ready,
   input  axi_mem_pkg::ax_req_t aw,
   input  logic                 aw_valid,
   output logic                 aw_ready,
   input  axi_mem_pkg::w_beat_t w,
   input  logic                 w_valid,
   output logic                 w_ready,
   output axi_mem_pkg::resp_t   b_resp,
   output logic                 b_valid,
   input  logic                 b_ready
);

   logic                      rd_en;
   logic [mem_words_log2-1:0] rd_index;
   axi_mem_pkg::data_t        rd_data;
   logic                      wr_en;
   logic [mem_words_log2-1:0] wr_index;
   axi_mem_pkg::data_t        wr_data;
   axi_mem_pkg::strb_t        wr_strb;

   axi_read_engine #(
      .mem_base       (mem_base),
      .mem_words_log2 (mem_words_log2)
   ) u_read (
      .clk (clk), .rst (rst),
      .ar (ar), .ar_valid (ar_valid), .ar_ready (ar_ready),
      .r (r), .r_valid (r_valid), .r_ready (r_ready),
      .rd_en (rd_en), .rd_index (rd_index), .rd_data (rd_data)
   );

   axi_write_engine #(
      .mem_base       (mem_base),
      .mem_words_log2 (mem_words_log2)
   ) u_write (
      .clk (clk), .rst (rst),
      .aw (aw), .aw_valid (aw_valid), .aw_ready (aw_ready),
      .w (w), .w_valid (w_valid), .w_ready (w_ready),
      .b_resp (b_resp), .b_valid (b_valid), .b_ready (b_ready),
      .wr_en (wr_en), .wr_index (wr_index), .wr_data (wr_data), .wr_strb (wr_strb)
   );

   // reads and writes run in parallel on separate ports
   mem_array #(
      .mem_words_log2 (mem_words_log2)
   ) u_mem (
      .clk (clk),
      .rd_en (rd_en), .rd_index (rd_index), .rd_data (rd_data),
      .wr_en (wr_en), .wr_index (wr_index), .wr_data (wr_data), .wr_strb (wr_strb)
   );

endmodule

`default_nettype wire

//--- design/axi_write_engine.sv
// ======================================================================
// AW/W/B channel FSM, writes each beat on its W transfer and returns
// the worst response seen over the burst
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine #(
   parameter axi_mem_pkg::addr_t mem_base       = 32'h8000_0000,
   parameter integer             mem_words_log2 = 12
) (
   input  logic                      clk,
   input  logic                      rst,
   input  axi_mem_pkg::ax_req_t      aw,
   input  logic                      aw_valid,
   output logic                      aw_ready,
   input  axi_mem_pkg::w_beat_t      w,
   input  logic                      w_valid,
   output logic                      w_ready,
   output axi_mem_pkg::resp_t        b_resp,
   output logic                      b_valid,
   input  logic                      b_ready,
   output logic                      wr_en,
   output logic [mem_words_log2-1:0] wr_index,
   output axi_mem_pkg::data_t        wr_data,
   output axi_mem_pkg::strb_t        wr_strb
);

   typedef enum logic [1:0] {st_idle, st_data, st_resp} state_t;

   state_t               state;
   axi_mem_pkg::ax_req_t req;
   axi_mem_pkg::len_t    cnt;
   axi_mem_pkg::resp_t   err;       // sticky over the burst
   axi_mem_pkg::resp_t   beat_err;
   axi_mem_pkg::addr_t   beat_addr;
   axi_mem_pkg::addr_t   offs;
   logic                 in_window;
   logic                 last_beat;
   logic                 w_fire;

   burst_addr_gen u_addr_gen (
      .req       (req),
      .count     (cnt),
      .beat_addr (beat_addr)
   );

   assign offs      = beat_addr - mem_base;
   assign in_window = (offs >> (mem_words_log2 + 3)) == '0;

   assign aw_ready  = (state == st_idle);
   assign w_ready   = (state == st_data);
   assign b_valid   = (state == st_resp);
   assign b_resp    = err;

   assign last_beat = (cnt == req.len);
   assign w_fire    = w_valid && w_ready;

   // out-of-window beats are dropped
   assign wr_en    = w_fire && in_window;
   assign wr_index = offs[mem_words_log2+2:3];
   assign wr_data  = w.data;
   assign wr_strb  = w.strb;

   always_comb begin
      if (!in_window) beat_err = axi_mem_pkg::resp_decerr;
      else if (w.last != last_beat) beat_err = axi_mem_pkg::resp_slverr;
      else beat_err = axi_mem_pkg::resp_okay;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: if (aw_valid) begin
               req   <= aw;
               cnt   <= '0;
               err   <= axi_mem_pkg::resp_okay;
               state <= st_data;
            end
            st_data: if (w_fire) begin
               if (beat_err > err) err <= beat_err;  // decerr over slverr
               if (last_beat) state <= st_resp;
               else cnt <= cnt + 8'd1;
            end
            st_resp: if (b_ready) state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/axi_read_engine.sv
// ======================================================================
// AR/R channel FSM, fetches one beat ahead and holds r under back-pressure
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine #(
   parameter axi_mem_pkg::addr_t mem_base       = 32'h8000_0000,
   parameter integer             mem_words_log2 = 12
) (
   input  logic                      clk,
   input  logic                      rst,
   input  axi_mem_pkg::ax_req_t      ar,
   input  logic                      ar_valid,
   output logic                      ar_ready,
   output axi_mem_pkg::r_beat_t      r,
   output logic                      r_valid,
   input  logic                      r_ready,
   output logic                      rd_en,
   output logic [mem_words_log2-1:0] rd_index,
   input  axi_mem_pkg::data_t        rd_data
);

   typedef enum logic [1:0] {st_idle, st_fetch, st_send} state_t;

   state_t               state;
   axi_mem_pkg::ax_req_t req;
   axi_mem_pkg::len_t    cnt;        // beat held in the memory register
   axi_mem_pkg::len_t    fetch_cnt;
   axi_mem_pkg::addr_t   beat_addr;
   axi_mem_pkg::addr_t   offs;
   logic                 in_window;
   logic                 oow_q;      // held beat was out of window
   logic                 last_beat;

   burst_addr_gen u_addr_gen (
      .req       (req),
      .count     (fetch_cnt),
      .beat_addr (beat_addr)
   );

   // in send, the address is for the next beat
   assign fetch_cnt = (state == st_send) ? cnt + 8'd1 : cnt;

   assign offs      = beat_addr - mem_base;
   assign in_window = (offs >> (mem_words_log2 + 3)) == '0;
   assign rd_index  = offs[mem_words_log2+2:3];

   assign ar_ready  = (state == st_idle);
   assign r_valid   = (state == st_send);
   assign last_beat = (cnt == req.len);

   assign rd_en = (state == st_fetch) || (r_valid && r_ready && !last_beat);

   always_comb begin
      r.data = oow_q ? '0 : rd_data;
      r.resp = oow_q ? axi_mem_pkg::resp_decerr : axi_mem_pkg::resp_okay;
      r.last = last_beat;
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         oow_q <= !in_window;  // tracks the word going into rd_data
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: if (ar_valid) begin
               req   <= ar;
               cnt   <= '0;
               state <= st_fetch;
            end
            st_fetch: state <= st_send;
            st_send: if (r_ready) begin
               if (last_beat) state <= st_idle;
               else cnt <= cnt + 8'd1;
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/mem_array.sv
// ======================================================================
// 64-bit word memory, registered read held while rd_en is low,
// byte-strobed write port
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module mem_array #(
   parameter integer mem_words_log2 = 12
) (
   input  logic                      clk,
   input  logic                      rd_en,
   input  logic [mem_words_log2-1:0] rd_index,
   output axi_mem_pkg::data_t        rd_data,
   input  logic                      wr_en,
   input  logic [mem_words_log2-1:0] wr_index,
   input  axi_mem_pkg::data_t        wr_data,
   input  axi_mem_pkg::strb_t        wr_strb
);

   localparam integer num_words = 2 ** mem_words_log2;

   axi_mem_pkg::data_t mem [0:num_words-1];

   // read register only moves on rd_en
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_index];  // old word on same-cycle write
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < 8; i++) begin
            if (wr_strb[i]) begin
               mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- design/burst_addr_gen.sv
// ======================================================================
// beat address decode for FIXED, INCR and WRAP bursts, combinational
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen (
   input  axi_mem_pkg::ax_req_t req,
   input  axi_mem_pkg::len_t    count,
   output axi_mem_pkg::addr_t   beat_addr
);

   axi_mem_pkg::addr_t offset;     // count times the step
   axi_mem_pkg::addr_t wrap_mask;  // wrap block size minus one
   axi_mem_pkg::addr_t incr_addr;

   assign offset    = axi_mem_pkg::addr_t'(count) << req.size;
   assign incr_addr = req.addr + offset;

   // block is (len+1) beats, len limited to 1/3/7/15 for wrap
   assign wrap_mask = ((axi_mem_pkg::addr_t'(req.len) + 32'd1) << req.size) - 32'd1;

   always_comb begin
      case (req.burst)
         axi_mem_pkg::burst_fixed: begin
            beat_addr = req.addr;
         end
         axi_mem_pkg::burst_wrap: begin
            // keep bits above the block, wrap the low part
            beat_addr = (req.addr & ~wrap_mask) | (incr_addr & wrap_mask);
         end
         default: begin
            beat_addr = incr_addr;  // incr, reserved code treated alike
         end
      endcase
   end

endmodule

`default_nettype wire

//--- design/axi_mem_pkg.sv
// ======================================================================
// shared bus widths, burst and response codes, and channel structs
// for the AXI burst memory slave, referenced by scoped name
// ======================================================================
`default_nettype none

package axi_mem_pkg;

   typedef logic [31:0] addr_t;
   typedef logic [63:0] data_t;
   typedef logic [7:0]  strb_t;
   typedef logic [7:0]  len_t;   // beats minus one
   typedef logic [2:0]  size_t;  // log2 bytes per beat

   typedef enum logic [1:0] {
      burst_fixed = 2'b00,
      burst_incr  = 2'b01,
      burst_wrap  = 2'b10
   } burst_t;

   // ordered by severity, higher code wins when merged
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10,
      resp_decerr = 2'b11
   } resp_t;

   // address request, shared by AR and AW
   typedef struct packed {
      addr_t  addr;
      len_t   len;
      size_t  size;
      burst_t burst;
   } ax_req_t;

   typedef struct packed {
      data_t data;
      strb_t strb;
      logic  last;
   } w_beat_t;

   typedef struct packed {
      data_t data;
      resp_t resp;
      logic  last;
   } r_beat_t;

endpackage

`default_nettype wire
